// ==== logic/change_maker.sv ====
// greedy split of the change amount into 50, 20, 10, 5 and 1 coins, latched on settle
`timescale 1ns/100ps
`include "vm_settings.svh"

module change_maker (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 settle,
	input  vm_pkg::balance_t     change_amt,
	output vm_pkg::coin_counts_t coin_counts
);
	import vm_pkg::*;

	localparam balance_t DENOM [5] = '{
		`VM_COIN_A,
		`VM_COIN_B,
		`VM_COIN_C,
		`VM_COIN_D,
		`VM_COIN_E
	};

	// largest coin first, remainder moves down the list
	function automatic coin_counts_t split_change(input balance_t amt);
		balance_t     rem;
		coin_counts_t cnt;
		rem = amt;
		for (int k = 0; k < $size(DENOM); k++) begin
			cnt[k] = count_t'(rem / DENOM[k]);
			rem    = rem % DENOM[k];
		end
		return cnt;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			coin_counts <= '0;
		else if (settle)
			coin_counts <= split_change(change_amt);
	end

endmodule

// ==== logic/coin_bank.sv ====
// credit register, adds coins and settles a buy or return, and offers the change amount
`timescale 1ns/100ps

module coin_bank (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             coin_add,
	input  vm_pkg::balance_t in_coin,
	input  logic             settle,
	input  vm_pkg::item_t    cmd_item,
	input  vm_pkg::price_t   sel_price,
	output vm_pkg::balance_t balance,
	output logic             paid,
	output vm_pkg::balance_t change_amt
);
	import vm_pkg::*;

	balance_t price_ext;
	logic     is_return;
	logic     afford;

	assign price_ext = balance_t'(sel_price);
	assign is_return = (cmd_item == '0);
	assign afford    = !is_return && (balance >= price_ext);

	// only meaningful while settle is high
	always_comb begin
		if (is_return)
			change_amt = balance;
		else if (afford)
			change_amt = balance - price_ext;
		else
			change_amt = '0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			balance <= '0;
			paid    <= 1'b0;
		end else begin
			paid <= settle && afford;
			if (coin_add)
				balance <= balance + in_coin;
			else if (settle && (is_return || afford))
				balance <= '0;
			// unpaid buy keeps the credit
		end
	end

endmodule

// ==== logic/price_table.sv ====
// six item prices, filled in order by the load burst and read back by item code
`timescale 1ns/100ps
`include "vm_settings.svh"

module price_table (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           load_en,
	input  vm_pkg::price_t in_item_price,
	input  vm_pkg::item_t  cmd_item,
	output vm_pkg::price_t sel_price
);
	import vm_pkg::*;

	price_t prices [`VM_ITEMS];
	item_t  load_idx;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			load_idx <= '0;
			for (int i = 0; i < `VM_ITEMS; i++)
				prices[i] <= '0;
		end else if (load_en) begin
			load_idx <= load_idx + 1'b1;
			// extra beats past item 6 are dropped
			if (load_idx < item_t'(`VM_ITEMS))
				prices[load_idx] <= in_item_price;
		end else begin
			load_idx <= '0;
		end
	end

	// code 0 reads as free
	always_comb begin
		sel_price = '0;
		if ((cmd_item != '0) && (cmd_item <= item_t'(`VM_ITEMS)))
			sel_price = prices[cmd_item - 1'b1];
	end

endmodule

// ==== logic/report_serializer.sv ====
// six-beat result burst: dispensed item and change counts on out_consumer, sales per beat
`timescale 1ns/100ps
`include "vm_settings.svh"

module report_serializer (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          report_start,
	input  logic                          paid,
	input  vm_pkg::item_t                 cmd_item,
	input  vm_pkg::coin_counts_t          coin_counts,
	input  vm_pkg::sell_t [`VM_ITEMS-1:0] sell_counts,
	output logic                          out_valid,
	output vm_pkg::count_t                out_consumer,
	output vm_pkg::sell_t                 out_sell_num,
	output logic                          report_busy
);
	import vm_pkg::*;

	localparam int BEAT_W = $clog2(`VM_REPORT_BEATS);

	logic              active;
	logic              sold;
	logic [BEAT_W-1:0] beat;

	// ------------------------------
	// beat counter
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			sold   <= 1'b0;
			beat   <= '0;
		end else if (report_start) begin
			// paid pulses alongside report_start
			active <= 1'b1;
			sold   <= paid;
			beat   <= '0;
		end else if (active) begin
			if (beat == BEAT_W'(`VM_REPORT_BEATS - 1)) begin
				active <= 1'b0;
				beat   <= '0;
			end else begin
				beat <= beat + 1'b1;
			end
		end
	end

	assign out_valid   = active;
	assign report_busy = active;

	// ------------------------------
	// beat data
	// ------------------------------
	always_comb begin
		out_consumer = '0;
		out_sell_num = '0;
		if (active) begin
			if (beat == '0)
				out_consumer = sold ? count_t'(cmd_item) : '0;
			else
				out_consumer = coin_counts[beat - 1'b1];
			// beat j carries item j+1
			out_sell_num = sell_counts[beat];
		end
	end

endmodule

// ==== logic/sales_tally.sv ====
// per-item sales counters, cleared by a price load and bumped once per paid purchase
`timescale 1ns/100ps
`include "vm_settings.svh"

module sales_tally (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          load_en,
	input  logic                          settle,
	input  logic                          paid,
	input  vm_pkg::item_t                 cmd_item,
	output vm_pkg::sell_t [`VM_ITEMS-1:0] sell_counts
);
	import vm_pkg::*;

	item_t sold_item;
	logic  bump;

	// item is captured at settle, the bump follows with paid
	assign bump = paid && (sold_item != '0) && (sold_item <= item_t'(`VM_ITEMS));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sold_item   <= '0;
			sell_counts <= '0;
		end else begin
			if (settle)
				sold_item <= cmd_item;
			if (load_en)
				sell_counts <= '0;
			else if (bump)
				sell_counts[sold_item - 1'b1] <= sell_counts[sold_item - 1'b1] + 1'b1;
		end
	end

endmodule

// ==== logic/vending_machine.sv ====
// vending machine top, ties the controller to the price, credit, change, sales and report blocks
`timescale 1ns/100ps
`include "vm_settings.svh"

module vending_machine (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_item_valid,
	input  logic                  in_coin_valid,
	input  logic [`VM_COIN_W-1:0] in_coin,
	input  logic                  in_rtn_coin,
	input  vm_pkg::item_t         in_buy_item,
	input  vm_pkg::price_t        in_item_price,
	output vm_pkg::balance_t      out_monitor,
	output logic                  out_valid,
	output vm_pkg::count_t        out_consumer,
	output vm_pkg::sell_t         out_sell_num
);
	import vm_pkg::*;

	logic                  load_en;
	logic                  coin_add;
	logic                  settle;
	logic                  report_start;
	logic                  report_busy;
	logic                  paid;
	item_t                 cmd_item;
	price_t                sel_price;
	balance_t              change_amt;
	coin_counts_t          coin_counts;
	sell_t [`VM_ITEMS-1:0] sell_counts;

	vm_control u_control (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_item_valid (in_item_valid),
		.in_coin_valid (in_coin_valid),
		.in_buy_item   (in_buy_item),
		.in_rtn_coin   (in_rtn_coin),
		.report_busy   (report_busy),
		.load_en       (load_en),
		.coin_add      (coin_add),
		.settle        (settle),
		.report_start  (report_start),
		.cmd_item      (cmd_item)
	);

	price_table u_prices (
		.clk           (clk),
		.rst_n         (rst_n),
		.load_en       (load_en),
		.in_item_price (in_item_price),
		.cmd_item      (cmd_item),
		.sel_price     (sel_price)
	);

	// balance is the monitor output itself
	coin_bank u_bank (
		.clk        (clk),
		.rst_n      (rst_n),
		.coin_add   (coin_add),
		.in_coin    (balance_t'(in_coin)),
		.settle     (settle),
		.cmd_item   (cmd_item),
		.sel_price  (sel_price),
		.balance    (out_monitor),
		.paid       (paid),
		.change_amt (change_amt)
	);

	change_maker u_change (
		.clk         (clk),
		.rst_n       (rst_n),
		.settle      (settle),
		.change_amt  (change_amt),
		.coin_counts (coin_counts)
	);

	sales_tally u_sales (
		.clk         (clk),
		.rst_n       (rst_n),
		.load_en     (load_en),
		.settle      (settle),
		.paid        (paid),
		.cmd_item    (cmd_item),
		.sell_counts (sell_counts)
	);

	report_serializer u_report (
		.clk          (clk),
		.rst_n        (rst_n),
		.report_start (report_start),
		.paid         (paid),
		.cmd_item     (cmd_item),
		.coin_counts  (coin_counts),
		.sell_counts  (sell_counts),
		.out_valid    (out_valid),
		.out_consumer (out_consumer),
		.out_sell_num (out_sell_num),
		.report_busy  (report_busy)
	);

endmodule

// ==== logic/vm_control.sv ====
// transaction FSM, decides which inputs are honored and strobes the datapath through a settle
`timescale 1ns/100ps
`include "vm_settings.svh"

module vm_control (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          in_item_valid,
	input  logic          in_coin_valid,
	input  vm_pkg::item_t in_buy_item,
	input  logic          in_rtn_coin,
	input  logic          report_busy,
	output logic          load_en,
	output logic          coin_add,
	output logic          settle,
	output logic          report_start,
	output vm_pkg::item_t cmd_item
);
	import vm_pkg::*;

	localparam int LAT_W = $clog2(`VM_SETTLE_LAT);

	vm_state_t        state;
	vm_state_t        state_nxt;
	logic [LAT_W-1:0] lat_cnt;
	logic             buy_ok;
	logic             cmd_take;

	// ------------------------------
	// input qualification
	// ------------------------------

	// codes past the last item are not a purchase
	assign buy_ok   = (in_buy_item != '0) && (in_buy_item <= item_t'(`VM_ITEMS));
	assign cmd_take = (state == IDLE) && !in_coin_valid && (in_rtn_coin || buy_ok);
	assign coin_add = (state == IDLE) && in_coin_valid;

	// settle one cycle after the command, report start right before the burst
	assign settle       = (state == SETTLE) && (lat_cnt == LAT_W'(`VM_SETTLE_LAT - 2));
	assign report_start = (state == SETTLE) && (lat_cnt == LAT_W'(`VM_SETTLE_LAT - 1));

	// ------------------------------
	// next state
	// ------------------------------
	always_comb begin
		state_nxt = state;
		load_en   = 1'b0;
		case (state)
			IDLE: begin
				if (cmd_take) begin
					state_nxt = SETTLE;
				end else if (in_item_valid && !in_coin_valid) begin
					state_nxt = LOAD;
					load_en   = 1'b1;
				end
			end
			LOAD: begin
				load_en = in_item_valid;
				if (!in_item_valid)
					state_nxt = IDLE;
			end
			SETTLE: begin
				if (report_start)
					state_nxt = REPORT;
			end
			REPORT: begin
				// hold off new work until the burst is out
				if (!report_busy)
					state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= IDLE;
			lat_cnt  <= '0;
			cmd_item <= '0;
		end else begin
			state <= state_nxt;
			if (state == SETTLE)
				lat_cnt <= lat_cnt + 1'b1;
			else
				lat_cnt <= '0;
			// return wins over a buy in the same cycle
			if (cmd_take)
				cmd_item <= in_rtn_coin ? '0 : in_buy_item;
		end
	end

endmodule

// ==== logic/vm_pkg.sv ====
// shared datapath types and controller states, imported by every vending machine block
`include "vm_settings.svh"

package vm_pkg;

	typedef logic [`VM_PRICE_W-1:0] price_t;
	typedef logic [`VM_BAL_W-1:0]   balance_t;

	// 0 is no item, 1 to 6 pick an item
	typedef logic [`VM_ITEM_W-1:0]  item_t;

	typedef logic [`VM_COUNT_W-1:0] count_t;
	typedef logic [`VM_SELL_W-1:0]  sell_t;

	// [0] counts 50s down to [4] counting 1s
	typedef count_t [4:0] coin_counts_t;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		SETTLE,
		REPORT
	} vm_state_t;

endpackage

// ==== logic/vm_settings.svh ====
// widths, item count and coin set of the vending machine, included by the package and RTL
`ifndef VM_SETTINGS_SVH
`define VM_SETTINGS_SVH

// item set
`define VM_ITEMS        6
`define VM_ITEM_W       3
`define VM_PRICE_W      5

// credit and coin input
`define VM_BAL_W        9
`define VM_COIN_W       6

// report burst
`define VM_COUNT_W      4
`define VM_SELL_W       6
`define VM_REPORT_BEATS 6

// change denominations, largest first
`define VM_COIN_A       50
`define VM_COIN_B       20
`define VM_COIN_C       10
`define VM_COIN_D       5
`define VM_COIN_E       1

// command sample to first report beat
`define VM_SETTLE_LAT   3

`endif

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the vending machine testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vending_machine.f \
	--top-module vending_machine_tb -Mdir obj_dir -o vending_machine_sim
status=0
./obj_dir/vending_machine_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "Simulation FAILED" sim.log || [ "$status" -ne 0 ]; then
	exit 1
fi
exit 0

// ==== tests/vending_machine_chk.sv ====
// port-level protocol and arithmetic checks, bound onto the vending machine top
`timescale 1ns/100ps
`include "vm_settings.svh"

module vending_machine_chk (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  in_coin_valid,
	input logic [`VM_COIN_W-1:0] in_coin,
	input vm_pkg::balance_t      out_monitor,
	input logic                  out_valid,
	input vm_pkg::count_t        out_consumer,
	input vm_pkg::sell_t         out_sell_num
);
	import vm_pkg::*;

	int fail_cnt = 0;

	// report data only inside a burst
	a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> (out_consumer == '0) && (out_sell_num == '0))
		else begin
			fail_cnt++;
			$error("report data seen outside a burst");
		end

	// exactly six beats per burst
	a_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(out_valid) |-> $past(out_valid, 2) && $past(out_valid, 3) && $past(out_valid, 4)
			&& $past(out_valid, 5) && $past(out_valid, 6) && !$past(out_valid, 7))
		else begin
			fail_cnt++;
			$error("report burst length is not six beats");
		end

	// greedy change never holds more than 2x20, 1x10, 1x5 or 4x1
	a_greedy: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(out_valid) |-> ($past(out_consumer, 1) <= 4) && ($past(out_consumer, 2) <= 1)
			&& ($past(out_consumer, 3) <= 1) && ($past(out_consumer, 4) <= 2))
		else begin
			fail_cnt++;
			$error("change counts are not a greedy breakdown");
		end

	// credit moves only by a coin or a clear
	a_balance_step: assert property (@(posedge clk) disable iff (!rst_n)
		(out_monitor != $past(out_monitor)) |-> (out_monitor == '0) || ($past(in_coin_valid)
			&& (out_monitor == $past(out_monitor) + balance_t'($past(in_coin)))))
		else begin
			fail_cnt++;
			$error("out_monitor changed without a coin or a clear");
		end

	a_busy_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $stable(out_monitor))
		else begin
			fail_cnt++;
			$error("out_monitor changed during a report burst");
		end

endmodule

bind vending_machine vending_machine_chk chk0 (
	.clk           (clk),
	.rst_n         (rst_n),
	.in_coin_valid (in_coin_valid),
	.in_coin       (in_coin),
	.out_monitor   (out_monitor),
	.out_valid     (out_valid),
	.out_consumer  (out_consumer),
	.out_sell_num  (out_sell_num)
);

// ==== tests/vending_machine_tb.sv ====
// testbench for the vending machine, runs coin, return, buy, reload and busy scenarios
`timescale 1ns/100ps
`include "vm_settings.svh"

module vending_machine_tb;
	import vm_pkg::*;

	logic                  clk;
	logic                  rst_n;
	logic                  in_item_valid;
	logic                  in_coin_valid;
	logic [`VM_COIN_W-1:0] in_coin;
	logic                  in_rtn_coin;
	item_t                 in_buy_item;
	price_t                in_item_price;
	balance_t              out_monitor;
	logic                  out_valid;
	count_t                out_consumer;
	sell_t                 out_sell_num;

	integer seed = 32'h86a5_684f;
	int     errors = 0;
	int     tests_run = 0;
	int     tests_failed = 0;
	int     test_base = 0;
	int     price_m [1:`VM_ITEMS];
	int     sales_m [1:`VM_ITEMS];
	int     bal_m;
	int     item;

	vending_machine dut0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_item_valid (in_item_valid),
		.in_coin_valid (in_coin_valid),
		.in_coin       (in_coin),
		.in_rtn_coin   (in_rtn_coin),
		.in_buy_item   (in_buy_item),
		.in_item_price (in_item_price),
		.out_monitor   (out_monitor),
		.out_valid     (out_valid),
		.out_consumer  (out_consumer),
		.out_sell_num  (out_sell_num)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic int err_total();
		return errors + dut0.chk0.fail_cnt;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	// coins of one value in the change, larger coins taken out first
	function automatic int coins_of(input int amount, input int beat);
		int denom [5] = '{`VM_COIN_A, `VM_COIN_B, `VM_COIN_C, `VM_COIN_D, `VM_COIN_E};
		int left;
		int cnt;
		left = amount;
		cnt = 0;
		for (int k = 0; k < beat; k++) begin
			cnt = 0;
			while (left >= denom[k]) begin
				left -= denom[k];
				cnt++;
			end
		end
		return cnt;
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		assert (actual == expected)
		else begin
			errors++;
			$display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (err_total() == test_base) begin
			$display("test %-12s ok", name);
		end else begin
			tests_failed++;
			$display("test %-12s failed", name);
		end
		test_base = err_total();
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------
	task automatic load_prices();
		@(posedge clk);
		for (int i = 1; i <= `VM_ITEMS; i++) begin
			price_m[i] = rand_range(2, 31);
			sales_m[i] = 0;
			in_item_valid <= 1'b1;
			in_item_price <= price_t'(price_m[i]);
			@(posedge clk);
		end
		in_item_valid <= 1'b0;
	endtask

	task automatic insert_coin(input int value);
		@(posedge clk);
		in_coin_valid <= 1'b1;
		in_coin       <= `VM_COIN_W'(value);
		@(posedge clk);
		in_coin_valid <= 1'b0;
		@(negedge clk);
		bal_m += value;
		check_value("out_monitor", bal_m, int'(out_monitor));
	endtask

	// buy (item) or return (0), then gather the burst and compare with the model
	task automatic run_command(input int buy, input logic busy_coins);
		int   n;
		int   change;
		int   exp_bal;
		logic paid;
		int   cons [$];
		int   sells [$];
		paid = (buy != 0) && (bal_m >= price_m[buy]);
		change = (buy == 0) ? bal_m : (paid ? bal_m - price_m[buy] : 0);
		exp_bal = ((buy == 0) || paid) ? 0 : bal_m;
		if (paid)
			sales_m[buy]++;
		@(posedge clk);
		in_rtn_coin <= (buy == 0);
		in_buy_item <= item_t'(buy);
		@(posedge clk);
		in_rtn_coin <= 1'b0;
		in_buy_item <= '0;
		n = 0;
		@(negedge clk);
		while (!out_valid && n < 20) begin
			@(negedge clk);
			n++;
			if (n == `VM_SETTLE_LAT - 1)
				check_value("out_monitor", exp_bal, int'(out_monitor));
		end
		check_value("out_valid rise cycle", `VM_SETTLE_LAT, n);
		if (!out_valid)
			$display("out_valid did not rise within 20 cycles of the command");
		n = 0;
		while (out_valid && n < 20) begin
			cons.push_back(int'(out_consumer));
			sells.push_back(int'(out_sell_num));
			@(posedge clk);
			if (busy_coins) begin
				in_coin_valid <= 1'b1;
				in_coin       <= `VM_COIN_W'(rand_range(1, 63));
			end
			@(negedge clk);
			n++;
		end
		check_value("out_valid beats", `VM_REPORT_BEATS, n);
		@(posedge clk);
		in_coin_valid <= 1'b0;
		for (int b = 0; b < cons.size() && b < `VM_REPORT_BEATS; b++) begin
			check_value($sformatf("out_consumer beat %0d", b),
				(b == 0) ? (paid ? buy : 0) : coins_of(change, b), cons[b]);
			check_value($sformatf("out_sell_num beat %0d", b), sales_m[b + 1], sells[b]);
		end
		bal_m = exp_bal;
		@(negedge clk);
		check_value("out_monitor", bal_m, int'(out_monitor));
	endtask

	initial begin
		rst_n         = 1'b0;
		in_item_valid = 1'b0;
		in_coin_valid = 1'b0;
		in_coin       = '0;
		in_rtn_coin   = 1'b0;
		in_buy_item   = '0;
		in_item_price = '0;
		bal_m         = 0;
		for (int i = 1; i <= `VM_ITEMS; i++) begin
			price_m[i] = 0;
			sales_m[i] = 0;
		end
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("out_valid", 0, int'(out_valid));
		check_value("out_consumer", 0, int'(out_consumer));
		check_value("out_sell_num", 0, int'(out_sell_num));
		check_value("out_monitor", 0, int'(out_monitor));
		run_command(0, 1'b0);
		end_test("reset");

		load_prices();
		repeat (6) insert_coin(rand_range(1, 63));
		end_test("coins");
		run_command(0, 1'b0);
		end_test("return");

		repeat (2) begin
			item = rand_range(1, `VM_ITEMS);
			while (bal_m < price_m[item])
				insert_coin(rand_range(1, 63));
			run_command(item, 1'b0);
		end
		end_test("paid buy");

		// one short of the price
		item = rand_range(1, `VM_ITEMS);
		insert_coin(price_m[item] - 1);
		run_command(item, 1'b0);
		end_test("unpaid buy");

		load_prices();
		item = rand_range(1, `VM_ITEMS);
		while (bal_m < price_m[item])
			insert_coin(rand_range(1, 63));
		run_command(item, 1'b0);
		end_test("price reload");

		insert_coin(rand_range(1, 63));
		run_command(0, 1'b1);
		end_test("busy inputs");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total());
		if (err_total() == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== vending_machine.f ====
+incdir+logic
logic/vm_pkg.sv
logic/vm_control.sv
logic/price_table.sv
logic/coin_bank.sv
logic/change_maker.sv
logic/sales_tally.sv
logic/report_serializer.sv
logic/vending_machine.sv
tests/vending_machine_chk.sv
tests/vending_machine_tb.sv
